//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - src/rv_pkg.sv
      - src/decode_if.sv
      - src/instr_decoder.sv
      - src/reg_file.sv
      - src/alu.sv
      - src/pc_unit.sv
      - src/core_ctrl.sv
      - src/rv_core.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/rv_core_tb.sv

//--- all.f
+incdir+include
src/rv_pkg.sv
src/decode_if.sv
src/instr_decoder.sv
src/reg_file.sv
src/alu.sv
src/pc_unit.sv
src/core_ctrl.sv
src/rv_core.sv
tb/rv_core_tb.sv

//--- src/alu.sv
module alu (
    decode_if.sink        dec,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    output rv_pkg::word_t result
);
    import rv_pkg::*;

    word_t      op_b;
    logic [4:0] shamt;

    assign op_b  = dec.use_imm ? dec.imm : rs2_data;
    assign shamt = op_b[4:0];

    always_comb
    begin
        case (dec.alu_op)
            alu_add:  result = rs1_data + op_b;
            alu_sub:  result = rs1_data - op_b;
            alu_sll:  result = rs1_data << shamt;
            alu_slt:  result = word_t'($signed(rs1_data) < $signed(op_b));
            alu_sltu: result = word_t'(rs1_data < op_b);
            alu_xor:  result = rs1_data ^ op_b;
            alu_srl:  result = rs1_data >> shamt;
            alu_sra:  result = word_t'($signed(rs1_data) >>> shamt);
            alu_or:   result = rs1_data | op_b;
            alu_and:  result = rs1_data & op_b;
            default:  result = rs1_data + op_b;
        endcase
    end

endmodule

//--- src/core_ctrl.sv
module core_ctrl (
    input  logic            clk,
    input  logic            rst,
    decode_if.sink          dec,
    input  rv_pkg::word_t   pc,
    input  rv_pkg::word_t   pc_plus4,
    input  rv_pkg::word_t   result,
    input  rv_pkg::word_t   rs2_data,
    output logic            latch,
    output logic            pc_update,
    output logic            rd_write,
    output rv_pkg::word_t   rd_data,
    output logic            instr_read,
    output rv_pkg::word_t   instr_addr,
    output logic            data_read,
    output rv_pkg::strobe_t data_write,
    output rv_pkg::word_t   data_addr,
    output rv_pkg::word_t   data_in,
    input  rv_pkg::word_t   data_out
);
    import rv_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        exec;
    logic        writes_rd;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_fetch;
        else
            state <= state_next;
    end

    always_comb
    begin
        case (state)
            st_fetch:   state_next = st_decode;
            st_decode:  state_next = st_execute;
            st_execute: state_next = (dec.iclass == cls_load) ? st_load_wb : st_fetch;
            default:    state_next = st_fetch;
        endcase
    end

    assign exec = (state == st_execute);

    // Instruction side
    assign instr_read = (state == st_fetch);
    assign instr_addr = pc;
    assign latch      = (state == st_decode);
    assign pc_update  = exec;

    // Data side addressed by the ALU result
    assign data_read  = exec && (dec.iclass == cls_load);
    assign data_write = (exec && dec.iclass == cls_store) ? store_all_lanes : '0;
    assign data_addr  = result;
    assign data_in    = rs2_data;

    always_comb
    begin
        case (dec.iclass)
            cls_alu, cls_lui, cls_auipc, cls_jal, cls_jalr: writes_rd = 1'b1;
            default:                                        writes_rd = 1'b0;
        endcase
    end

    assign rd_write = (exec && writes_rd) || (state == st_load_wb);

    always_comb
    begin
        case (dec.iclass)
            cls_lui:           rd_data = dec.imm;
            cls_auipc:         rd_data = pc + dec.imm;
            cls_jal, cls_jalr: rd_data = pc_plus4;  // Link value
            cls_load:          rd_data = data_out;
            default:           rd_data = result;
        endcase
    end

endmodule

//--- src/decode_if.sv
interface decode_if;
    import rv_pkg::*;

    reg_idx_t     rs1;
    reg_idx_t     rs2;
    reg_idx_t     rd;
    word_t        imm;      // Sign-extended per format
    logic [2:0]   funct3;
    alu_op_t      alu_op;
    logic         use_imm;  // Second ALU operand is imm
    instr_class_t iclass;

    modport source (
        output rs1, rs2, rd, imm, funct3, alu_op, use_imm, iclass
    );

    modport sink (
        input rs1, rs2, rd, imm, funct3, alu_op, use_imm, iclass
    );

endinterface

//--- src/instr_decoder.sv
module instr_decoder (
    input  logic          clk,
    input  logic          rst,
    input  logic          latch,
    input  rv_pkg::word_t instr_out,
    decode_if.source      dec
);
    import rv_pkg::*;

    word_t      ir;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    always_ff @(posedge clk)
    begin
        if (rst)
            ir <= '0;  // Opcode zero decodes as nop
        else if (latch)
            ir <= instr_out;
    end

    assign opcode = ir[6:0];
    assign funct3 = ir[14:12];
    assign funct7 = ir[31:25];

    assign dec.rs1     = ir[19:15];
    assign dec.rs2     = ir[24:20];
    assign dec.rd      = ir[11:7];
    assign dec.funct3  = funct3;
    assign dec.use_imm = (opcode != op_reg);

    always_comb
    begin
        case (opcode)
            op_imm, op_load, op_jalr: dec.imm = {{20{ir[31]}}, ir[31:20]};
            op_store:                 dec.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
            op_branch: dec.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
            op_lui, op_auipc:         dec.imm = {ir[31:12], 12'b0};
            op_jal: dec.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
            default:                  dec.imm = '0;
        endcase
    end

    always_comb
    begin
        dec.alu_op = alu_add;  // Addresses and the JALR target
        dec.iclass = cls_nop;
        case (opcode)
            op_reg, op_imm:
            begin
                dec.iclass = cls_alu;
                case (funct3)
                    3'b000:  dec.alu_op = (opcode == op_reg && funct7[5]) ? alu_sub : alu_add;
                    3'b001:  dec.alu_op = alu_sll;
                    3'b010:  dec.alu_op = alu_slt;
                    3'b011:  dec.alu_op = alu_sltu;
                    3'b100:  dec.alu_op = alu_xor;
                    3'b101:  dec.alu_op = funct7[5] ? alu_sra : alu_srl;
                    3'b110:  dec.alu_op = alu_or;
                    default: dec.alu_op = alu_and;
                endcase
                if (opcode == op_reg && funct7[0])
                    dec.iclass = cls_nop;  // No multiply group
            end
            op_load:
            begin
                if (funct3 == 3'b010)
                    dec.iclass = cls_load;  // LW only
            end
            op_store:
            begin
                if (funct3 == 3'b010)
                    dec.iclass = cls_store;  // SW only
            end
            op_branch: dec.iclass = cls_branch;
            op_lui:    dec.iclass = cls_lui;
            op_auipc:  dec.iclass = cls_auipc;
            op_jal:    dec.iclass = cls_jal;
            op_jalr:   dec.iclass = cls_jalr;
            default:   dec.iclass = cls_nop;
        endcase
    end

endmodule

//--- src/pc_unit.sv
module pc_unit (
    input  logic          clk,
    input  logic          rst,
    decode_if.sink        dec,
    input  rv_pkg::word_t rs1_data,
    input  rv_pkg::word_t rs2_data,
    input  rv_pkg::word_t result,
    input  logic          pc_update,
    output rv_pkg::word_t pc,
    output rv_pkg::word_t pc_plus4
);
    import rv_pkg::*;

    logic  taken;
    word_t target;
    word_t next_pc;

    assign pc_plus4 = pc + pc_step;
    assign target   = pc + dec.imm;  // Branch and JAL target

    always_comb
    begin
        case (dec.funct3)
            f3_beq:  taken = (rs1_data == rs2_data);
            f3_bne:  taken = (rs1_data != rs2_data);
            f3_blt:  taken = ($signed(rs1_data) < $signed(rs2_data));
            f3_bge:  taken = ($signed(rs1_data) >= $signed(rs2_data));
            f3_bltu: taken = (rs1_data < rs2_data);
            f3_bgeu: taken = (rs1_data >= rs2_data);
            default: taken = 1'b0;
        endcase
    end

    always_comb
    begin
        case (dec.iclass)
            cls_branch: next_pc = taken ? target : pc_plus4;
            cls_jal:    next_pc = target;
            cls_jalr:   next_pc = {result[xlen-1:1], 1'b0};
            default:    next_pc = pc_plus4;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= reset_pc;
        else if (pc_update)
            pc <= next_pc;
    end

endmodule

//--- src/reg_file.sv
module reg_file (
    input  logic          clk,
    input  logic          rst,
    decode_if.sink        dec,
    input  logic          rd_write,
    input  rv_pkg::word_t rd_data,
    output rv_pkg::word_t rs1_data,
    output rv_pkg::word_t rs2_data
);
    import rv_pkg::*;

    word_t regs [2**reg_addr_w];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 2**reg_addr_w; i++)
                regs[i] <= '0;
        end
        else if (rd_write && dec.rd != '0)  // x0 stays zero
            regs[dec.rd] <= rd_data;
    end

    assign rs1_data = regs[dec.rs1];
    assign rs2_data = regs[dec.rs2];

endmodule

//--- src/rv_core.sv
module rv_core (
    input  logic            clk,
    input  logic            rst,
    output logic            instr_read,
    output rv_pkg::word_t   instr_addr,
    input  rv_pkg::word_t   instr_out,
    output logic            data_read,
    output rv_pkg::strobe_t data_write,
    output rv_pkg::word_t   data_addr,
    output rv_pkg::word_t   data_in,
    input  rv_pkg::word_t   data_out
);
    import rv_pkg::*;

    logic  latch;
    logic  pc_update;
    logic  rd_write;
    word_t rd_data;
    word_t rs1_data;
    word_t rs2_data;
    word_t result;
    word_t pc;
    word_t pc_plus4;

    decode_if dec_bus ();

    instr_decoder u_decoder (
        .clk       (clk),
        .rst       (rst),
        .latch     (latch),
        .instr_out (instr_out),
        .dec       (dec_bus.source)
    );

    reg_file u_reg_file (
        .clk      (clk),
        .rst      (rst),
        .dec      (dec_bus.sink),
        .rd_write (rd_write),
        .rd_data  (rd_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    alu u_alu (
        .dec      (dec_bus.sink),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .result   (result)
    );

    pc_unit u_pc_unit (
        .clk       (clk),
        .rst       (rst),
        .dec       (dec_bus.sink),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .result    (result),
        .pc_update (pc_update),
        .pc        (pc),
        .pc_plus4  (pc_plus4)
    );

    core_ctrl u_ctrl (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec_bus.sink),
        .pc         (pc),
        .pc_plus4   (pc_plus4),
        .result     (result),
        .rs2_data   (rs2_data),
        .latch      (latch),
        .pc_update  (pc_update),
        .rd_write   (rd_write),
        .rd_data    (rd_data),
        .instr_read (instr_read),
        .instr_addr (instr_addr),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_in    (data_in),
        .data_out   (data_out)
    );

endmodule

//--- src/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    typedef logic [xlen-1:0]       word_t;
    typedef logic [reg_addr_w-1:0] reg_idx_t;
    typedef logic [3:0]            strobe_t;

    // Major opcodes
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;

    // Branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    typedef enum logic [3:0] {
        cls_alu,
        cls_load,
        cls_store,
        cls_branch,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_nop
    } instr_class_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_decode,
        st_execute,
        st_load_wb
    } ctrl_state_t;

    localparam word_t   pc_step         = 32'd4;
    localparam strobe_t store_all_lanes = 4'b1111;  // Word stores only
    localparam word_t   reset_pc        = 32'h0000_0000;

endpackage

//--- include/rv_iss.svh
`ifndef RV_ISS_SVH
`define RV_ISS_SVH

// Architectural model that fills exp_pc, exp_gap, exp_addr and exp_data
function automatic void rv_iss();
    word_t      x [32];
    word_t      mem [dmem_depth];
    word_t      pc, ins, a, b, res, next, addr;
    word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
    logic [6:0] opc;
    logic [2:0] f3;
    logic       wr, taken;
    int         i;
    for (i = 0; i < 32; i++)
        x[i] = '0;
    for (i = 0; i < dmem_depth; i++)
        mem[i] = dmem_init[i];
    pc = reset_pc;
    for (i = 0; i < 4 * imem_depth; i++)
    begin
        ins = imem[pc[9:2]];
        exp_pc.push_back(pc);
        if (ins == enc_j(21'd0, 5'd0))
            break;  // Jump to itself ends the program
        opc   = ins[6:0];
        f3    = ins[14:12];
        a     = x[ins[19:15]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'b0};
        imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        b     = (opc == op_reg) ? x[ins[24:20]] : imm_i;
        exp_gap.push_back((opc == op_load && f3 == 3'b010) ? 4 : 3);
        wr    = 1'b0;
        res   = '0;
        next  = pc + 32'd4;
        case (opc)
            op_reg, op_imm:
            begin
                wr = !(opc == op_reg && ins[25]);
                case (f3)
                    3'b000:  res = (opc == op_reg && ins[30]) ? a - b : a + b;
                    3'b001:  res = a << b[4:0];
                    3'b010:  res = word_t'($signed(a) < $signed(b));
                    3'b011:  res = word_t'(a < b);
                    3'b100:  res = a ^ b;
                    3'b101:  res = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
                    3'b110:  res = a | b;
                    default: res = a & b;
                endcase
            end
            op_load:
            begin
                addr = a + imm_i;
                wr   = (f3 == 3'b010);
                res  = mem[addr[7:2]];
            end
            op_store:
            begin
                addr = a + imm_s;
                if (f3 == 3'b010)
                begin
                    exp_addr.push_back(addr);
                    exp_data.push_back(x[ins[24:20]]);
                    mem[addr[7:2]] = x[ins[24:20]];
                end
            end
            op_branch:
            begin
                b = x[ins[24:20]];
                case (f3)
                    f3_beq:  taken = (a == b);
                    f3_bne:  taken = (a != b);
                    f3_blt:  taken = ($signed(a) < $signed(b));
                    f3_bge:  taken = ($signed(a) >= $signed(b));
                    f3_bltu: taken = (a < b);
                    f3_bgeu: taken = (a >= b);
                    default: taken = 1'b0;
                endcase
                if (taken)
                    next = pc + imm_b;
            end
            op_lui:   {wr, res} = {1'b1, imm_u};
            op_auipc: {wr, res} = {1'b1, pc + imm_u};
            op_jal:
            begin
                {wr, res} = {1'b1, pc + 32'd4};
                next = pc + imm_j;
            end
            op_jalr:
            begin
                {wr, res} = {1'b1, pc + 32'd4};
                next = (a + imm_i) & ~32'd1;
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0)
            x[ins[11:7]] = res;
        pc = next;
    end
endfunction

`endif

//--- tb/rv_core_tb.sv
module rv_core_tb;
    import rv_pkg::*;

    localparam int imem_depth   = 256;
    localparam int dmem_depth   = 64;
    localparam int n_ops        = 40;
    localparam int seed         = 71343;
    localparam int reset_cycles = 8;

    logic    clk;
    logic    rst;
    logic    instr_read;
    word_t   instr_addr;
    word_t   instr_out;
    logic    data_read;
    strobe_t data_write;
    word_t   data_addr;
    word_t   data_in;
    word_t   data_out;

    word_t imem [imem_depth];
    word_t dmem [dmem_depth];
    word_t dmem_init [dmem_depth];
    word_t exp_pc [$];
    int    exp_gap [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    n_instr;
    int    cycle = 0;
    int    cycle_limit = 100000;  // Replaced once the model has run
    int    fetch_idx = 0;
    int    last_fetch = 0;
    logic  done = 1'b0;

    `include "rv_iss.svh"

    rv_core UUT (
        .clk        (clk),
        .rst        (rst),
        .instr_read (instr_read),
        .instr_addr (instr_addr),
        .instr_out  (instr_out),
        .data_read  (data_read),
        .data_write (data_write),
        .data_addr  (data_addr),
        .data_in    (data_in),
        .data_out   (data_out)
    );

    always #20 clk = ~clk;

    function automatic word_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                    reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(logic [12:0] imm, reg_idx_t rs2, reg_idx_t rs1,
                                    logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic word_t enc_j(logic [20:0] imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic void emit(word_t w);
        imem[n_instr] = w;
        n_instr++;
    endfunction

    function automatic logic [11:0] rand_offset();
        return 12'(($urandom % 32) * 4);  // Word aligned within data memory
    endfunction

    function automatic void gen_program();
        reg_idx_t    rd, rs1, rs2, rt;
        logic [2:0]  f3;
        logic [11:0] imm;
        int          k;
        n_instr = 0;
        for (k = 1; k <= 8; k++)
        begin
            emit({20'($urandom), 5'(k), op_lui});
            emit(enc_i(12'($urandom), 5'(k), 3'b000, 5'(k), op_imm));
        end
        for (k = 0; k < n_ops; k++)
        begin
            rd  = 5'(1 + $urandom % 15);
            rt  = 5'(1 + $urandom % 15);
            rs1 = 5'($urandom % 16);
            rs2 = 5'($urandom % 16);
            f3  = 3'($urandom);
            imm = 12'($urandom);
            case ($urandom % 7)
                0: emit(enc_r(((f3 == 0 || f3 == 5) && $urandom % 2) ? 7'h20 : 7'h00,
                              rs2, rs1, f3, rd));
                1:
                begin
                    if (f3 == 3'b001)
                        imm = {7'h00, imm[4:0]};
                    if (f3 == 3'b101)
                        imm = {($urandom % 2) ? 7'h20 : 7'h00, imm[4:0]};
                    emit(enc_i(imm, rs1, f3, rd, op_imm));
                end
                2: emit({20'($urandom), rd, ($urandom % 2) ? op_lui : op_auipc});
                3:
                begin
                    case ($urandom % 6)
                        0:       f3 = f3_beq;
                        1:       f3 = f3_bne;
                        2:       f3 = f3_blt;
                        3:       f3 = f3_bge;
                        4:       f3 = f3_bltu;
                        default: f3 = f3_bgeu;
                    endcase
                    emit(enc_b(13'd8, rs2, rs1, f3));  // Skips the increment when taken
                    emit(enc_i(12'd1, rd, 3'b000, rd, op_imm));
                end
                4:
                begin
                    emit(enc_j(21'd8, rd));
                    emit(enc_i(12'd1, rd, 3'b000, rd, op_imm));
                end
                5:
                begin
                    emit({20'd0, rt, op_auipc});
                    emit(enc_i(12'd13, rt, 3'b000, rd, op_jalr));  // Odd target loses bit 0
                    emit(enc_i(12'd1, rd, 3'b000, rd, op_imm));
                end
                default:
                begin
                    imm = rand_offset();
                    emit(enc_s(imm, rs2, 5'd0));
                    emit(enc_i(imm, 5'd0, 3'b010, rd, op_load));
                end
            endcase
            emit(enc_s(rand_offset(), rd, 5'd0));
        end
        emit(enc_j(21'd0, 5'd0));
    endfunction

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_strobe(string name, strobe_t got, strobe_t exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        if (got !== exp)
            abort_run($sformatf("Fail %s: got %h, expected %h", name, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle > cycle_limit)
            abort_run("Timeout: the core never reached the end of the program");
    end

    // Memory models and compare process
    always @(negedge clk)
    begin
        if (cycle >= reset_cycles && !done)  // From the fetch in which reset drops
        begin
            if (instr_read)
            begin
                check_bit("data_read", data_read, 1'b0);
                check_strobe("data_write", data_write, 4'b0000);
                if (fetch_idx >= exp_pc.size())
                    abort_run("The core fetched more instructions than the program runs");
                check_word("instr_addr", instr_addr, exp_pc[fetch_idx]);
                if (fetch_idx > 0)
                    check_word("instr_read gap", word_t'(cycle - last_fetch),
                               word_t'(exp_gap[fetch_idx - 1]));
                instr_out <= imem[instr_addr[9:2]];
                last_fetch = cycle;
                fetch_idx++;
                if (fetch_idx == exp_pc.size())
                    done = 1'b1;
            end
            if (data_read)
                data_out <= dmem[data_addr[7:2]];
            if (data_write != 4'b0000)
            begin
                if (exp_addr.size() == 0)
                    abort_run("The core stored more words than the program stores");
                check_strobe("data_write", data_write, store_all_lanes);
                check_word("data_addr", data_addr, exp_addr.pop_front());
                check_word("data_in", data_in, exp_data.pop_front());
                dmem[data_addr[7:2]] = data_in;
            end
        end
    end

    initial
    begin
        clk       = 1'b0;
        rst       = 1'b1;
        instr_out = '0;
        data_out  = '0;
        void'($urandom(seed));
        for (int i = 0; i < imem_depth; i++)
            imem[i] = enc_i(12'(i), 5'd0, 3'b000, 5'd0, op_imm);  // addi x0 filler
        for (int i = 0; i < dmem_depth; i++)
        begin
            dmem_init[i] = word_t'(i) * 32'h9e37_79b9 ^ 32'h5a5a_0000;
            dmem[i]      = dmem_init[i];
        end
        gen_program();
        rv_iss();
        cycle_limit = reset_cycles + 4 * exp_pc.size() + 50;
        repeat (reset_cycles) @(negedge clk);
        rst = 1'b0;
        wait (done);
        @(negedge clk);
        if (exp_addr.size() != 0)
            abort_run("The program ended before all expected stores were seen");
        else
        begin
            $display("Test passed");
            $finish;
        end
    end

endmodule
